/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int PREG_COUNT = 64;
    localparam int ROB_DEPTH  = 32;

    typedef logic [31:0]                   word_t;
    typedef logic [63:0]                   order_t;
    typedef logic [4:0]                    arch_reg_t;
    typedef logic [$clog2(PREG_COUNT)-1:0] phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]  rob_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage : core_pkg

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h1eceb000
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  imem_ready_i,
    input  logic  imem_rvalid_i,
    input  word_t imem_rdata_i,
    input  logic  iq_full_i,
    output word_t imem_addr_o,
    output logic  imem_read_o,
    output logic  iq_push_o,
    output word_t iq_inst_o,
    output word_t iq_pc_o
);

    typedef enum logic {
        REQUEST,
        WAIT
    } fetch_state_e;

    fetch_state_e state_q;
    word_t        pc_q;
    logic         armed_q;  // low in the first cycle out of reset

    assign imem_read_o = armed_q && (state_q == REQUEST) && imem_ready_i && !iq_full_i;
    assign iq_push_o   = (state_q == WAIT) && imem_rvalid_i;
    assign imem_addr_o = pc_q;
    assign iq_inst_o   = imem_rdata_i;
    assign iq_pc_o     = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= REQUEST;
            pc_q    <= RESET_PC;
            armed_q <= 1'b0;
        end else begin
            armed_q <= 1'b1;
            if (imem_read_o) begin
                state_q <= WAIT;
            end else if (iq_push_o) begin
                state_q <= REQUEST;
                pc_q    <= pc_q + 32'd4;    // one read outstanding, so advance on response
            end
        end
    end

endmodule : fetch_unit

`default_nettype wire

/* rtl/inst_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_queue
import core_pkg::*;
#(
    parameter int IQ_DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push_i,
    input  word_t inst_i,
    input  word_t pc_i,
    input  logic  pop_i,
    output word_t inst_o,
    output word_t pc_o,
    output logic  full_o,
    output logic  empty_o
);

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    word_t            inst_mem [IQ_DEPTH];
    word_t            pc_mem   [IQ_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(IQ_DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign inst_o  = inst_mem[rd_ptr_q];    // head visible without a pop
    assign pc_o    = pc_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[wr_ptr_q] <= inst_i;
            pc_mem[wr_ptr_q]   <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule : inst_queue

`default_nettype wire

/* rtl/rename_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_decode
import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      iq_empty_i,
    input  word_t     iq_inst_i,
    input  word_t     iq_pc_i,
    input  logic      rob_full_i,
    input  rob_idx_t  rob_tail_i,
    input  logic      res_valid_i,
    input  phys_reg_t res_pd_i,
    input  logic      free_valid_i,
    input  phys_reg_t free_pd_i,
    output logic      iq_pop_o,
    output logic      disp_valid_o,
    output alu_op_e   disp_op_o,
    output phys_reg_t disp_ps1_o,
    output phys_reg_t disp_ps2_o,
    output phys_reg_t disp_pd_o,
    output logic      disp_we_o,
    output logic      disp_use_imm_o,
    output word_t     disp_imm_o,
    output rob_idx_t  disp_rob_o,
    output arch_reg_t disp_rd_o,
    output word_t     disp_pc_o
);

    localparam int FL_DEPTH = PREG_COUNT - 32;  // everything beyond the identity map
    localparam int FL_W     = $clog2(FL_DEPTH);

    phys_reg_t             rat_q  [32];
    phys_reg_t             fl_mem [FL_DEPTH];
    logic [FL_W-1:0]       fl_head_q;
    logic [FL_W-1:0]       fl_tail_q;
    logic [FL_W:0]         fl_count_q;
    logic [PREG_COUNT-1:0] busy_q;

    logic [6:0] opcode;
    logic [2:0] funct3;
    arch_reg_t  rd;
    arch_reg_t  rs1;
    arch_reg_t  rs2;
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;
    logic       need_dest;
    logic       alloc;

    assign opcode    = iq_inst_i[6:0];
    assign funct3    = iq_inst_i[14:12];
    assign rd        = iq_inst_i[11:7];
    assign is_op     = (opcode == OPC_OP);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_lui    = (opcode == OPC_LUI);
    assign need_dest = (is_op || is_op_imm || is_lui) && (rd != '0);
    assign rs1       = (is_op || is_op_imm) ? iq_inst_i[19:15] : '0;   // x0 never busy
    assign rs2       = is_op ? iq_inst_i[24:20] : '0;

    assign disp_ps1_o = rat_q[rs1];
    assign disp_ps2_o = rat_q[rs2];
    assign iq_pop_o   = !iq_empty_i && !rob_full_i && !(need_dest && fl_count_q == '0)
                        && !busy_q[disp_ps1_o] && !busy_q[disp_ps2_o];
    assign alloc      = iq_pop_o && need_dest;

    assign disp_valid_o   = iq_pop_o;
    assign disp_we_o      = need_dest;
    assign disp_pd_o      = need_dest ? fl_mem[fl_head_q] : '0;
    assign disp_rd_o      = need_dest ? rd : '0;
    assign disp_use_imm_o = is_op_imm || is_lui;
    assign disp_imm_o     = is_lui ? {iq_inst_i[31:12], 12'b0}
                                   : {{20{iq_inst_i[31]}}, iq_inst_i[31:20]};
    assign disp_rob_o     = rob_tail_i;
    assign disp_pc_o      = iq_pc_i;

    always_comb begin
        case (funct3)
            3'b000:  disp_op_o = (is_op && iq_inst_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  disp_op_o = ALU_SLL;
            3'b010:  disp_op_o = ALU_SLT;
            3'b011:  disp_op_o = ALU_SLTU;
            3'b100:  disp_op_o = ALU_XOR;
            3'b101:  disp_op_o = iq_inst_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  disp_op_o = ALU_OR;
            default: disp_op_o = ALU_AND;
        endcase
        if (is_lui) begin
            disp_op_o = ALU_PASS_B;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rat_q[i] <= phys_reg_t'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= phys_reg_t'(32 + i);
            end
            fl_head_q  <= '0;
            fl_tail_q  <= '0;
            fl_count_q <= (FL_W + 1)'(FL_DEPTH);
            busy_q     <= '0;
        end else begin
            if (res_valid_i) begin
                busy_q[res_pd_i] <= 1'b0;
            end
            if (alloc) begin
                rat_q[rd]         <= disp_pd_o;
                busy_q[disp_pd_o] <= 1'b1;
                fl_head_q         <= fl_head_q + 1'b1;
            end
            if (free_valid_i) begin
                fl_mem[fl_tail_q] <= free_pd_i;
                fl_tail_q         <= fl_tail_q + 1'b1;
            end
            case ({free_valid_i, alloc})
                2'b10:   fl_count_q <= fl_count_q + 1'b1;
                2'b01:   fl_count_q <= fl_count_q - 1'b1;
                default: fl_count_q <= fl_count_q;
            endcase
        end
    end

endmodule : rename_decode

`default_nettype wire

/* rtl/phys_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_regfile
import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  phys_reg_t ra_i,
    input  phys_reg_t rb_i,
    input  logic      wr_valid_i,
    input  phys_reg_t wr_pd_i,
    input  word_t     wr_data_i,
    output word_t     ra_data_o,
    output word_t     rb_data_o
);

    word_t regs_q [PREG_COUNT];

    // architectural registers start out as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PREG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_valid_i && wr_pd_i != '0) begin
            regs_q[wr_pd_i] <= wr_data_i;
        end
    end

    assign ra_data_o = (ra_i == '0) ? '0 : regs_q[ra_i];
    assign rb_data_o = (rb_i == '0) ? '0 : regs_q[rb_i];

endmodule : phys_regfile

`default_nettype wire

/* rtl/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute
import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_valid_i,
    input  alu_op_e   disp_op_i,
    input  phys_reg_t disp_ps1_i,
    input  phys_reg_t disp_ps2_i,
    input  phys_reg_t disp_pd_i,
    input  logic      disp_we_i,
    input  logic      disp_use_imm_i,
    input  word_t     disp_imm_i,
    input  rob_idx_t  disp_rob_i,
    output phys_reg_t ra_o,
    output phys_reg_t rb_o,
    input  word_t     ra_data_i,
    input  word_t     rb_data_i,
    output logic      res_valid_o,
    output phys_reg_t res_pd_o,
    output rob_idx_t  res_rob_o,
    output logic      res_we_o,
    output word_t     res_value_o
);

    logic      valid_q;
    alu_op_e   op_q;
    phys_reg_t ps1_q;
    phys_reg_t ps2_q;
    phys_reg_t pd_q;
    logic      we_q;
    logic      use_imm_q;
    word_t     imm_q;
    rob_idx_t  rob_q;
    word_t     op_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= disp_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            op_q      <= disp_op_i;
            ps1_q     <= disp_ps1_i;
            ps2_q     <= disp_ps2_i;
            pd_q      <= disp_pd_i;
            we_q      <= disp_we_i;
            use_imm_q <= disp_use_imm_i;
            imm_q     <= disp_imm_i;
            rob_q     <= disp_rob_i;
        end
    end

    assign ra_o = ps1_q;    // operands read in the cycle after dispatch
    assign rb_o = ps2_q;
    assign op_b = use_imm_q ? imm_q : rb_data_i;

    always_comb begin
        case (op_q)
            ALU_SUB:    res_value_o = ra_data_i - op_b;
            ALU_SLL:    res_value_o = ra_data_i << op_b[4:0];
            ALU_SLT:    res_value_o = {31'b0, $signed(ra_data_i) < $signed(op_b)};
            ALU_SLTU:   res_value_o = {31'b0, ra_data_i < op_b};
            ALU_XOR:    res_value_o = ra_data_i ^ op_b;
            ALU_SRL:    res_value_o = ra_data_i >> op_b[4:0];
            ALU_SRA:    res_value_o = $signed(ra_data_i) >>> op_b[4:0];
            ALU_OR:     res_value_o = ra_data_i | op_b;
            ALU_AND:    res_value_o = ra_data_i & op_b;
            ALU_PASS_B: res_value_o = op_b;
            default:    res_value_o = ra_data_i + op_b;
        endcase
    end

    assign res_valid_o = valid_q;
    assign res_pd_o    = pd_q;
    assign res_rob_o   = rob_q;
    assign res_we_o    = valid_q && we_q;   // qualified write strobe

endmodule : alu_execute

`default_nettype wire

/* rtl/commit_result.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_result
import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_valid_i,
    input  word_t     disp_pc_i,
    input  arch_reg_t disp_rd_i,
    input  phys_reg_t disp_pd_i,
    input  logic      disp_we_i,
    input  logic      res_valid_i,
    input  rob_idx_t  res_rob_i,
    input  word_t     res_value_i,
    output logic      rob_full_o,
    output rob_idx_t  rob_tail_o,
    output logic      free_valid_o,
    output phys_reg_t free_pd_o,
    output logic      commit_valid_o,
    output word_t     commit_pc_o,
    output order_t    commit_order_o,
    output arch_reg_t commit_rd_o,
    output logic      commit_we_o,
    output word_t     commit_value_o
);

    localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

    word_t                pc_q    [ROB_DEPTH];
    arch_reg_t            rd_q    [ROB_DEPTH];
    phys_reg_t            pd_q    [ROB_DEPTH];
    word_t                value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] we_q;
    logic [ROB_DEPTH-1:0] done_q;
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [CNT_W-1:0]     count_q;
    order_t               order_q;
    phys_reg_t            rrat_q  [32];

    assign rob_full_o     = (count_q == CNT_W'(ROB_DEPTH));
    assign rob_tail_o     = tail_q;
    assign commit_valid_o = (count_q != '0) && done_q[head_q];
    assign commit_pc_o    = pc_q[head_q];
    assign commit_order_o = order_q;
    assign commit_rd_o    = rd_q[head_q];
    assign commit_we_o    = we_q[head_q];
    assign commit_value_o = value_q[head_q];
    assign free_valid_o   = commit_valid_o && commit_we_o;
    assign free_pd_o      = rrat_q[commit_rd_o];   // mapping being replaced

    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            pc_q[tail_q] <= disp_pc_i;
            rd_q[tail_q] <= disp_rd_i;
            pd_q[tail_q] <= disp_pd_i;
            we_q[tail_q] <= disp_we_i;
        end
        if (res_valid_i) begin
            value_q[res_rob_i] <= res_value_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            order_q <= '0;
            done_q  <= '0;
            for (int i = 0; i < 32; i++) begin
                rrat_q[i] <= phys_reg_t'(i);
            end
        end else begin
            if (disp_valid_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (res_valid_i) begin
                done_q[res_rob_i] <= 1'b1;
            end
            if (commit_valid_o) begin
                head_q  <= head_q + 1'b1;
                order_q <= order_q + 1'b1;
                if (commit_we_o) begin
                    rrat_q[commit_rd_o] <= pd_q[head_q];
                end
            end
            case ({disp_valid_i, commit_valid_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule : commit_result

`default_nettype wire

/* rtl/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core
import core_pkg::*;
#(
    parameter word_t RESET_PC = 32'h1eceb000,
    parameter int    IQ_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst,
    output word_t     imem_addr_o,
    output logic      imem_read_o,
    input  logic      imem_ready_i,
    input  word_t     imem_rdata_i,
    input  logic      imem_rvalid_i,
    output logic      commit_valid_o,
    output word_t     commit_pc_o,
    output order_t    commit_order_o,
    output arch_reg_t commit_rd_o,
    output logic      commit_we_o,
    output word_t     commit_value_o
);

    logic      iq_push, iq_pop, iq_full, iq_empty;
    word_t     f_inst, f_pc, iq_inst, iq_pc;
    logic      rob_full, free_valid;
    rob_idx_t  rob_tail, disp_rob, res_rob;
    phys_reg_t free_pd, disp_ps1, disp_ps2, disp_pd, ra, rb, res_pd;
    logic      disp_valid, disp_we, disp_use_imm, res_valid, res_we;
    alu_op_e   disp_op;
    word_t     disp_imm, disp_pc, ra_data, rb_data, res_value;
    arch_reg_t disp_rd;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_i (
        .clk(clk), .rst(rst),
        .imem_ready_i(imem_ready_i), .imem_rvalid_i(imem_rvalid_i),
        .imem_rdata_i(imem_rdata_i), .iq_full_i(iq_full),
        .imem_addr_o(imem_addr_o), .imem_read_o(imem_read_o),
        .iq_push_o(iq_push), .iq_inst_o(f_inst), .iq_pc_o(f_pc)
    );

    inst_queue #(.IQ_DEPTH(IQ_DEPTH)) iq_i (
        .clk(clk), .rst(rst),
        .push_i(iq_push), .inst_i(f_inst), .pc_i(f_pc), .pop_i(iq_pop),
        .inst_o(iq_inst), .pc_o(iq_pc), .full_o(iq_full), .empty_o(iq_empty)
    );

    rename_decode rename_i (
        .clk(clk), .rst(rst),
        .iq_empty_i(iq_empty), .iq_inst_i(iq_inst), .iq_pc_i(iq_pc),
        .rob_full_i(rob_full), .rob_tail_i(rob_tail),
        .res_valid_i(res_valid), .res_pd_i(res_pd),
        .free_valid_i(free_valid), .free_pd_i(free_pd),
        .iq_pop_o(iq_pop), .disp_valid_o(disp_valid), .disp_op_o(disp_op),
        .disp_ps1_o(disp_ps1), .disp_ps2_o(disp_ps2), .disp_pd_o(disp_pd),
        .disp_we_o(disp_we), .disp_use_imm_o(disp_use_imm), .disp_imm_o(disp_imm),
        .disp_rob_o(disp_rob), .disp_rd_o(disp_rd), .disp_pc_o(disp_pc)
    );

    phys_regfile prf_i (
        .clk(clk), .rst(rst), .ra_i(ra), .rb_i(rb),
        .wr_valid_i(res_we), .wr_pd_i(res_pd), .wr_data_i(res_value),
        .ra_data_o(ra_data), .rb_data_o(rb_data)
    );

    alu_execute alu_i (
        .clk(clk), .rst(rst),
        .disp_valid_i(disp_valid), .disp_op_i(disp_op),
        .disp_ps1_i(disp_ps1), .disp_ps2_i(disp_ps2), .disp_pd_i(disp_pd),
        .disp_we_i(disp_we), .disp_use_imm_i(disp_use_imm), .disp_imm_i(disp_imm),
        .disp_rob_i(disp_rob), .ra_o(ra), .rb_o(rb),
        .ra_data_i(ra_data), .rb_data_i(rb_data),
        .res_valid_o(res_valid), .res_pd_o(res_pd), .res_rob_o(res_rob),
        .res_we_o(res_we), .res_value_o(res_value)
    );

    commit_result rob_i (
        .clk(clk), .rst(rst),
        .disp_valid_i(disp_valid), .disp_pc_i(disp_pc), .disp_rd_i(disp_rd),
        .disp_pd_i(disp_pd), .disp_we_i(disp_we),
        .res_valid_i(res_valid), .res_rob_i(res_rob), .res_value_i(res_value),
        .rob_full_o(rob_full), .rob_tail_o(rob_tail),
        .free_valid_o(free_valid), .free_pd_o(free_pd),
        .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
        .commit_order_o(commit_order_o), .commit_rd_o(commit_rd_o),
        .commit_we_o(commit_we_o), .commit_value_o(commit_value_o)
    );

endmodule : ooo_core

`default_nettype wire

/* verification/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb
import core_pkg::*;
();

    localparam word_t RESET_PC    = 32'h1eceb000;
    localparam word_t SEED        = 32'h340e_a1d6;
    localparam int    MAX_PROG    = 512;
    localparam int    TOTAL_INSTS = 12 + 40 + 200 + 60 + 300;
    localparam int    MAX_CYCLES  = TOTAL_INSTS * 16 + 6 * 50;   // slowest fetch plus stalls

    logic      clk;
    logic      rst;
    word_t     imem_addr;
    logic      imem_read;
    logic      imem_ready;
    word_t     imem_rdata;
    logic      imem_rvalid;
    logic      commit_valid;
    word_t     commit_pc;
    order_t    commit_order;
    arch_reg_t commit_rd;
    logic      commit_we;
    word_t     commit_value;

    word_t     prog_mem  [MAX_PROG];
    word_t     exp_pc    [MAX_PROG];
    arch_reg_t exp_rd    [MAX_PROG];
    logic      exp_we    [MAX_PROG];
    word_t     exp_value [MAX_PROG];
    word_t     arch_regs [32];
    int        prog_len;
    int        commits_seen;
    logic      running;

    word_t mem_rng;
    word_t prog_rng;
    logic  stall_mode;
    logic  in_reset;
    logic  req_seen;
    logic  pending;
    word_t req_addr;
    word_t resp_data;
    int    wait_left;
    int    low_left;
    int    checks;
    int    errors;
    int    cycle_count;

    ooo_core #(
        .RESET_PC(RESET_PC),
        .IQ_DEPTH(16)
    ) dut_i (
        .clk(clk), .rst(rst),
        .imem_addr_o(imem_addr), .imem_read_o(imem_read), .imem_ready_i(imem_ready),
        .imem_rdata_i(imem_rdata), .imem_rvalid_i(imem_rvalid),
        .commit_valid_o(commit_valid), .commit_pc_o(commit_pc),
        .commit_order_o(commit_order), .commit_rd_o(commit_rd),
        .commit_we_o(commit_we), .commit_value_o(commit_value)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic word_t lcg_next(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic expect_equal(input string what, input logic [63:0] got,
                                input logic [63:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERROR @%0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s (at %0t)", what, $time);
    endtask

    function automatic word_t r_type(input logic alt, input arch_reg_t rs2,
                                     input arch_reg_t rs1, input logic [2:0] f3,
                                     input arch_reg_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input arch_reg_t rs1,
                                     input logic [2:0] f3, input arch_reg_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input arch_reg_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // j picks add, sub, sll, slt, sltu, xor, srl, sra, or, and
    function automatic word_t op_inst(input int j, input arch_reg_t rd,
                                      input arch_reg_t rs1, input arch_reg_t rs2);
        logic [2:0] f3;
        logic       alt;
        alt = (j == 1) || (j == 7);
        case (j)
            0, 1:    f3 = 3'b000;
            2:       f3 = 3'b001;
            3:       f3 = 3'b010;
            4:       f3 = 3'b011;
            5:       f3 = 3'b100;
            6, 7:    f3 = 3'b101;
            8:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        return r_type(alt, rs2, rs1, f3, rd);
    endfunction

    // rv32i integer semantics for the reference model
    function automatic word_t isa_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic word_t imem_word(input word_t addr);
        word_t offset;
        offset = addr - RESET_PC;
        if (offset[1:0] == 2'b00 && offset < word_t'(prog_len * 4)) begin
            return prog_mem[offset >> 2];
        end
        return {addr[31:7] ^ addr[26:2], 7'b0000000};   // opcode 0 retires without a write
    endfunction

    task automatic add_inst(input word_t inst);
        arch_reg_t rd;
        logic [2:0] f3;
        logic      writes;
        word_t     val;
        rd     = inst[11:7];
        f3     = inst[14:12];
        writes = 1'b1;
        val    = '0;
        case (inst[6:0])
            OPC_LUI:    val = {inst[31:12], 12'b0};
            OPC_OP_IMM: val = isa_alu(f3, (f3 == 3'b101) && inst[30], arch_regs[inst[19:15]],
                                      {{20{inst[31]}}, inst[31:20]});
            OPC_OP:     val = isa_alu(f3, inst[30], arch_regs[inst[19:15]],
                                      arch_regs[inst[24:20]]);
            default:    writes = 1'b0;
        endcase
        writes = writes && (rd != '0);
        if (writes) begin
            arch_regs[rd] = val;
        end
        prog_mem[prog_len]  = inst;
        exp_pc[prog_len]    = RESET_PC + word_t'(prog_len * 4);
        exp_rd[prog_len]    = writes ? rd : '0;
        exp_we[prog_len]    = writes;
        exp_value[prog_len] = val;
        prog_len++;
    endtask

    function automatic word_t random_inst();
        word_t fields;
        word_t imm;
        prog_rng = lcg_next(prog_rng);
        fields   = prog_rng;
        prog_rng = lcg_next(prog_rng);
        imm      = prog_rng;
        case (fields[22:21])
            2'd0: return u_type(imm[31:12], fields[31:29]);
            2'd1: begin
                if (fields[16:14] == 3'b001) begin
                    return i_type({7'b0, imm[24:20]}, fields[28:26], 3'b001, fields[31:29]);
                end else if (fields[16:14] == 3'b101) begin
                    return i_type({1'b0, fields[13], 5'b0, imm[24:20]}, fields[28:26],
                                  3'b101, fields[31:29]);
                end
                return i_type(imm[31:20], fields[28:26], fields[16:14], fields[31:29]);
            end
            default: return op_inst(int'(fields[20:17]) % 10, fields[31:29], fields[28:26],
                                    fields[25:23]);
        endcase
    endfunction

    task automatic begin_program(input logic stall);
        @(posedge clk);
        running    = 1'b0;
        stall_mode = stall;
        prog_len   = 0;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end
    endtask

    task automatic reset_core();
        #1;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst          = 1'b0;
        commits_seen = 0;
        running      = 1'b1;
    endtask

    task automatic wait_commits();
        while (commits_seen < prog_len) begin
            @(posedge clk);
        end
    endtask

    // samples requests mid-cycle, where they are stable
    always @(negedge clk) begin
        in_reset = rst;
        req_seen = !rst && imem_read;
        req_addr = imem_addr;
        if (req_seen) begin
            checks += 2;
            assert (imem_ready) else report_failure("instruction read issued while ready was low");
            assert (!pending) else report_failure("second instruction read while one outstanding");
        end
    end

    // memory responds one to three cycles after the request
    always @(posedge clk) begin
        #1;
        imem_rvalid = 1'b0;
        if (in_reset) begin
            pending    = 1'b0;
            wait_left  = 0;
            low_left   = 0;
            imem_ready = 1'b1;
        end else begin
            if (req_seen) begin
                mem_rng   = lcg_next(mem_rng);
                wait_left = int'(mem_rng[31:24]) % 3;
                resp_data = imem_word(req_addr);
                pending   = 1'b1;
            end else if (pending) begin
                wait_left--;
            end
            if (pending && wait_left == 0) begin
                imem_rvalid = 1'b1;
                imem_rdata  = resp_data;
                pending     = 1'b0;
            end
            if (stall_mode && low_left > 0) begin
                imem_ready = 1'b0;
                low_left--;
            end else begin
                imem_ready = 1'b1;
                if (stall_mode) begin
                    mem_rng = lcg_next(mem_rng);
                    if (mem_rng[31:29] == 3'd0) begin
                        low_left = 2 + int'(mem_rng[28:26]);
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (running && commit_valid && commits_seen < prog_len) begin
            expect_equal("commit pc", commit_pc, exp_pc[commits_seen]);
            expect_equal("commit order", commit_order, 64'(commits_seen));
            expect_equal("commit rd", commit_rd, exp_rd[commits_seen]);
            expect_equal("commit write flag", commit_we, exp_we[commits_seen]);
            if (exp_we[commits_seen]) begin
                expect_equal("commit value", commit_value, exp_value[commits_seen]);
            end
            commits_seen++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d commits seen",
                     cycle_count, commits_seen, prog_len);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_reset_state();
        int waited;
        waited = 0;
        begin_program(1'b0);
        reset_core();
        @(negedge clk);
        expect_equal("imem_read_o after reset", imem_read, 0);
        expect_equal("commit_valid_o after reset", commit_valid, 0);
        while (!imem_read && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (imem_read) else report_failure("no instruction read within 10 cycles of reset");
        expect_equal("first fetch address", imem_addr, RESET_PC);
    endtask

    task automatic independent_ops();
        begin_program(1'b0);
        for (int i = 1; i <= 12; i++) begin
            case (i % 4)
                0:       add_inst(u_type(20'h12340 + 20'(i), arch_reg_t'(i)));
                1:       add_inst(i_type(12'(i * 37), 5'd0, 3'b000, arch_reg_t'(i)));
                2:       add_inst(i_type(12'hf00 | 12'(i), 5'd0, 3'b100, arch_reg_t'(i)));
                default: add_inst(i_type(12'h0a5, 5'd0, 3'b110, arch_reg_t'(i)));
            endcase
        end
        reset_core();
        wait_commits();
    endtask

    task automatic dependency_chains();
        arch_reg_t prev_rd;
        arch_reg_t rd;
        begin_program(1'b0);
        add_inst(u_type(20'h80000, 5'd1));
        add_inst(i_type(12'hffb, 5'd1, 3'b000, 5'd1));
        add_inst(u_type(20'h12345, 5'd2));
        add_inst(i_type(12'h678, 5'd2, 3'b000, 5'd2));
        add_inst(i_type(12'd7, 5'd0, 3'b000, 5'd3));
        prev_rd = 5'd1;
        for (int k = 0; k < 35; k++) begin
            rd = arch_reg_t'(4 + k % 4);
            add_inst(op_inst(k % 10, rd, prev_rd, arch_reg_t'(1 + k % 3)));
            prev_rd = rd;
        end
        reset_core();
        wait_commits();
    endtask

    task automatic free_list_recycling();
        begin_program(1'b0);
        for (int k = 0; k < 200; k++) begin
            if (k % 5 == 0) begin
                add_inst(i_type(12'(k), 5'd1, 3'b000, 5'd0));   // x0 target
            end else if (k % 5 == 1) begin
                add_inst(r_type(1'b0, 5'd2, 5'd0, 3'b000, 5'd1));
            end else begin
                add_inst(i_type(12'(k), arch_reg_t'(1 + (k + 1) % 3), 3'b000,
                                arch_reg_t'(1 + k % 3)));
            end
        end
        reset_core();
        wait_commits();
    endtask

    task automatic ready_stall_program();
        begin_program(1'b1);
        for (int k = 0; k < 60; k++) begin
            add_inst(random_inst());
        end
        reset_core();
        wait_commits();
    endtask

    task automatic random_program();
        begin_program(1'b0);
        for (int k = 0; k < 300; k++) begin
            add_inst(random_inst());
        end
        reset_core();
        wait_commits();
    endtask

    initial begin
        rst          = 1'b1;
        imem_ready   = 1'b1;
        imem_rvalid  = 1'b0;
        imem_rdata   = '0;
        mem_rng      = SEED;
        prog_rng     = SEED;
        stall_mode   = 1'b0;
        in_reset     = 1'b1;
        req_seen     = 1'b0;
        req_addr     = '0;
        pending      = 1'b0;
        wait_left    = 0;
        low_left     = 0;
        running      = 1'b0;
        prog_len     = 0;
        commits_seen = 0;
        checks       = 0;
        errors       = 0;
        cycle_count  = 0;
        check_reset_state();
        independent_ops();
        dependency_chains();
        free_list_recycling();
        ready_stall_program();
        random_program();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : core_tb

`default_nettype wire

/* verilog.f */
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/inst_queue.sv
rtl/rename_decode.sv
rtl/phys_regfile.sv
rtl/alu_execute.sv
rtl/commit_result.sv
rtl/ooo_core.sv
verification/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f verilog.f -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/core_tb_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^ALL CHECKS PASSED$"; then
    exit 0
fi
exit 1
